/* flist.f */
rtl/keypad_pkg.sv
rtl/keypad_scanner.sv
rtl/keypad_debouncer.sv
rtl/keypad_decoder.sv
rtl/key_fifo.sv
rtl/keypad_apb_regs.sv
rtl/keypad_top.sv
verification/keypad_matrix_model.sv
verification/tb_keypad.sv

/* rtl/key_fifo.sv */
`timescale 1ns/1ps

module key_fifo import keypad_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [KEY_CODE_W-1:0] wr_data,
    input  logic                  rd_en,
    output logic [KEY_CODE_W-1:0] rd_data,
    output logic                  empty,
    output logic [FIFO_CNT_W-1:0] count,
    output logic                  overflow_pulse
);

    logic [KEY_CODE_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  full;
    logic                  do_wr;
    logic                  do_rd;

    assign empty   = (count == '0);
    assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign rd_data = mem[rd_ptr];
    assign do_rd   = rd_en && !empty;
    assign do_wr   = wr_en && (!full || do_rd);  // a pop in the same cycle frees a slot.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            overflow_pulse <= 1'b0;
        end else begin
            overflow_pulse <= wr_en && !do_wr;
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    // the register block only pops when it has seen a non-empty status.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> !empty)
        else $error("FIFO popped while empty");

endmodule

/* rtl/keypad_apb_regs.sv */
`timescale 1ns/1ps

module keypad_apb_regs import keypad_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic [KEY_CODE_W-1:0] fifo_data,
    input  logic                  fifo_empty,
    input  logic [FIFO_CNT_W-1:0] fifo_count,
    input  logic                  overflow_pulse,
    input  logic                  ghost_pulse,
    output logic                  fifo_rd_en,
    output logic                  scan_en,
    output logic                  irq
);

    logic access;
    logic wr_access;
    logic addr_ok;
    logic irq_en;
    logic ovf_flag;
    logic ghost_flag;

    assign access     = psel && penable;
    assign wr_access  = access && pwrite;
    assign addr_ok    = (paddr == ADDR_CTRL) || (paddr == ADDR_STATUS) || (paddr == ADDR_DATA);
    assign pready     = 1'b1;  // every access completes in its first access cycle.
    assign pslverr    = access && !addr_ok;
    assign fifo_rd_en = access && !pwrite && (paddr == ADDR_DATA) && !fifo_empty;
    assign irq        = irq_en && !fifo_empty;

    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_CTRL:   prdata = {30'd0, irq_en, scan_en};
            ADDR_STATUS: prdata = {24'd0, fifo_count, 1'b0, ghost_flag, ovf_flag, !fifo_empty};
            ADDR_DATA:   prdata = fifo_empty ? '0 : {23'd0, 1'b1, 4'd0, fifo_data};
            default:     prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_en    <= 1'b0;
            irq_en     <= 1'b0;
            ovf_flag   <= 1'b0;
            ghost_flag <= 1'b0;
        end else begin
            if (wr_access && paddr == ADDR_CTRL) begin
                scan_en <= pwdata[0];
                irq_en  <= pwdata[1];
            end
            // a new event wins over a clear in the same cycle.
            if (overflow_pulse) begin
                ovf_flag <= 1'b1;
            end else if (wr_access && paddr == ADDR_STATUS && pwdata[1]) begin
                ovf_flag <= 1'b0;
            end
            if (ghost_pulse) begin
                ghost_flag <= 1'b1;
            end else if (wr_access && paddr == ADDR_STATUS && pwdata[2]) begin
                ghost_flag <= 1'b0;
            end
        end
    end

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
        else $error("APB penable seen without psel");

endmodule

/* rtl/keypad_debouncer.sv */
`timescale 1ns/1ps

module keypad_debouncer import keypad_pkg::*; #(
    parameter int DEBOUNCE_FRAMES = DEFAULT_DEBOUNCE_FRAMES
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_valid,
    input  logic [COORD_W-1:0] frame_coord,
    input  logic               frame_multi,
    output logic               press_valid,
    output logic [COORD_W-1:0] press_coord,
    output logic               press_multi
);

    localparam int RUN_W = $clog2(DEBOUNCE_FRAMES + 1);

    logic [COORD_W-1:0] cand_coord;
    logic               cand_multi;
    logic [RUN_W-1:0]   run_cnt;
    logic [COORD_W-1:0] stable_coord;
    logic               stable_multi;
    logic               same;
    logic               accept;
    logic               is_new;

    assign same   = ({frame_multi, frame_coord} == {cand_multi, cand_coord});
    assign is_new = ({frame_multi, frame_coord} != {stable_multi, stable_coord});

    // accept on the frame that completes the run, not on later ones.
    assign accept = frame_valid &&
                    (same ? (run_cnt == RUN_W'(DEBOUNCE_FRAMES - 1)) : (DEBOUNCE_FRAMES == 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cand_coord   <= NO_KEY;
            cand_multi   <= 1'b0;
            run_cnt      <= '0;
            stable_coord <= NO_KEY;
            stable_multi <= 1'b0;
            press_valid  <= 1'b0;
        end else begin
            press_valid <= accept && is_new && (frame_coord != NO_KEY);
            if (frame_valid) begin
                cand_coord <= frame_coord;
                cand_multi <= frame_multi;
                if (!same) begin
                    run_cnt <= RUN_W'(1);
                end else if (run_cnt != RUN_W'(DEBOUNCE_FRAMES)) begin
                    run_cnt <= run_cnt + 1'b1;  // saturates once stable.
                end
            end
            if (accept) begin
                stable_coord <= frame_coord;  // a stable empty frame rearms the same key.
                stable_multi <= frame_multi;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            press_coord <= frame_coord;
            press_multi <= frame_multi;
        end
    end

endmodule

/* rtl/keypad_decoder.sv */
`timescale 1ns/1ps

module keypad_decoder import keypad_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  press_valid,
    input  logic [COORD_W-1:0]    press_coord,
    input  logic                  press_multi,
    output logic                  key_valid,
    output logic [KEY_CODE_W-1:0] key_code,
    output logic                  ghost_pulse
);

    logic [NUM_ROWS-1:0] rows;
    logic [NUM_COLS-1:0] cols;
    logic                ghost;

    // returns the position of the first zero bit.
    function automatic logic [COL_IDX_W-1:0] cold_index(input logic [NUM_COLS-1:0] v);
        logic [COL_IDX_W-1:0] idx;
        idx = '0;
        for (int i = NUM_COLS - 1; i >= 0; i--) begin
            if (!v[i]) idx = COL_IDX_W'(i);
        end
        return idx;
    endfunction

    assign rows  = press_coord[COORD_W-1:NUM_COLS];
    assign cols  = press_coord[NUM_COLS-1:0];
    assign ghost = press_multi || !$onehot(~rows) || !$onehot(~cols);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_valid   <= 1'b0;
            ghost_pulse <= 1'b0;
        end else begin
            key_valid   <= press_valid && !ghost;
            ghost_pulse <= press_valid && ghost;
        end
    end

    always_ff @(posedge clk) begin
        if (press_valid) begin
            // row index times four plus column index.
            key_code <= {ROW_IDX_W'(cold_index(rows)), cold_index(cols)};
        end
    end

    // the debouncer only hands over patterns with at least one low row.
    a_press_has_key: assert property (@(posedge clk) disable iff (!rst_n)
        press_valid |-> (rows != '1))
        else $error("decoder got a press without any low row");

endmodule

/* rtl/keypad_pkg.sv */
package keypad_pkg;

    // matrix geometry. rows and columns are active low on the pins.
    localparam int NUM_ROWS   = 4;
    localparam int NUM_COLS   = 4;
    localparam int ROW_IDX_W  = $clog2(NUM_ROWS);
    localparam int COL_IDX_W  = $clog2(NUM_COLS);
    localparam int COORD_W    = NUM_ROWS + NUM_COLS;  // {row, col}, both one-cold.
    localparam int KEY_CODE_W = 4;

    // an all-ones pattern means no row was pulled low in the frame.
    localparam logic [COORD_W-1:0] NO_KEY = '1;

    localparam int DEFAULT_COL_DWELL       = 16;
    localparam int DEFAULT_DEBOUNCE_FRAMES = 4;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_CNT_W = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // register map, byte addresses of 32-bit words.
    localparam int APB_ADDR_W = 4;
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h4;
    localparam logic [APB_ADDR_W-1:0] ADDR_DATA   = 4'h8;

endpackage

/* rtl/keypad_scanner.sv */
`timescale 1ns/1ps

module keypad_scanner import keypad_pkg::*; #(
    parameter int COL_DWELL = DEFAULT_COL_DWELL
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                scan_en,
    input  logic [NUM_ROWS-1:0] row_in,
    output logic [NUM_COLS-1:0] col_out,
    output logic                frame_valid,
    output logic [COORD_W-1:0]  frame_coord,
    output logic                frame_multi
);

    localparam int DWELL_W = $clog2(COL_DWELL + 1);

    logic                 scan_active;
    logic [COL_IDX_W-1:0] col_idx;
    logic [DWELL_W-1:0]   dwell_cnt;
    logic                 hit_found;
    logic                 hit_multi;
    logic [COORD_W-1:0]   hit_coord;
    logic                 sample_now;
    logic                 row_hit;
    logic                 last_col;
    logic [COORD_W-1:0]   coord_next;
    logic                 multi_next;

    assign col_out    = scan_active ? ~(NUM_COLS'(1) << col_idx) : '1;
    assign sample_now = scan_active && (dwell_cnt == DWELL_W'(COL_DWELL - 1));
    assign row_hit    = (row_in != '1);
    assign last_col   = (col_idx == COL_IDX_W'(NUM_COLS - 1));

    // the first column with a low row wins, any later one marks the frame as multi.
    assign coord_next = hit_found ? hit_coord : (row_hit ? {row_in, col_out} : NO_KEY);
    assign multi_next = hit_multi || (hit_found && row_hit);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_active <= 1'b0;
            col_idx     <= '0;
            dwell_cnt   <= '0;
            hit_found   <= 1'b0;
            hit_multi   <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (!scan_en) begin
                scan_active <= 1'b0;  // park on column 0 with all columns high.
                col_idx     <= '0;
                dwell_cnt   <= '0;
                hit_found   <= 1'b0;
                hit_multi   <= 1'b0;
            end else begin
                scan_active <= 1'b1;
                if (sample_now) begin
                    dwell_cnt <= '0;
                    col_idx   <= col_idx + 1'b1;  // wraps back to column 0.
                    if (last_col) begin
                        frame_valid <= 1'b1;
                        hit_found   <= 1'b0;
                        hit_multi   <= 1'b0;
                    end else begin
                        hit_found <= hit_found || row_hit;
                        hit_multi <= multi_next;
                    end
                end else if (scan_active) begin
                    dwell_cnt <= dwell_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_now) begin
            hit_coord <= coord_next;
            if (last_col) begin
                frame_coord <= coord_next;
                frame_multi <= multi_next;
            end
        end
    end

    // one column is low and stays put until its rows have been sampled.
    a_one_col_low: assert property (@(posedge clk) disable iff (!rst_n)
        scan_en && scan_active && !sample_now |=> $onehot(~col_out) && $stable(col_out))
        else $error("scanner moved or doubled the low column inside a dwell");

endmodule

/* rtl/keypad_top.sv */
`timescale 1ns/1ps

module keypad_top import keypad_pkg::*; #(
    parameter int COL_DWELL       = DEFAULT_COL_DWELL,
    parameter int DEBOUNCE_FRAMES = DEFAULT_DEBOUNCE_FRAMES
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [NUM_COLS-1:0]   col_out,
    input  logic [NUM_ROWS-1:0]   row_in,
    output logic                  irq
);

    logic                  scan_en;
    logic                  frame_valid;
    logic [COORD_W-1:0]    frame_coord;
    logic                  frame_multi;
    logic                  press_valid;
    logic [COORD_W-1:0]    press_coord;
    logic                  press_multi;
    logic                  key_valid;
    logic [KEY_CODE_W-1:0] key_code;
    logic                  ghost_pulse;
    logic [KEY_CODE_W-1:0] fifo_data;
    logic                  fifo_empty;
    logic [FIFO_CNT_W-1:0] fifo_count;
    logic                  overflow_pulse;
    logic                  fifo_rd_en;

    keypad_scanner #(.COL_DWELL(COL_DWELL)) u_scanner (
        .clk, .rst_n, .scan_en, .row_in, .col_out,
        .frame_valid, .frame_coord, .frame_multi
    );

    keypad_debouncer #(.DEBOUNCE_FRAMES(DEBOUNCE_FRAMES)) u_debouncer (
        .clk, .rst_n, .frame_valid, .frame_coord, .frame_multi,
        .press_valid, .press_coord, .press_multi
    );

    keypad_decoder u_decoder (
        .clk, .rst_n, .press_valid, .press_coord, .press_multi,
        .key_valid, .key_code, .ghost_pulse
    );

    key_fifo u_fifo (
        .clk, .rst_n, .wr_en(key_valid), .wr_data(key_code), .rd_en(fifo_rd_en),
        .rd_data(fifo_data), .empty(fifo_empty), .count(fifo_count), .overflow_pulse
    );

    keypad_apb_regs u_regs (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .fifo_data, .fifo_empty, .fifo_count, .overflow_pulse, .ghost_pulse,
        .fifo_rd_en, .scan_en, .irq
    );

endmodule

/* verification/keypad_matrix_model.sv */
`timescale 1ns/1ps

module keypad_matrix_model import keypad_pkg::*; (
    input  logic [NUM_COLS-1:0]          col_out,
    input  logic [NUM_ROWS*NUM_COLS-1:0] pressed,
    output logic [NUM_ROWS-1:0]          row_in
);

    // a closed switch in a driven column pulls its row low, rows idle high.
    always_comb begin
        row_in = '1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                if (pressed[r*NUM_COLS + c] && !col_out[c]) begin
                    row_in[r] = 1'b0;
                end
            end
        end
    end

endmodule

/* verification/tb_keypad.sv */
`timescale 1ns/1ps

module tb_keypad import keypad_pkg::*; ();

    localparam int COL_DWELL_TB = 4;
    localparam int DEBOUNCE_TB  = 3;
    localparam int FRAME_CYCLES = NUM_COLS * COL_DWELL_TB;
    localparam int POLL_LIMIT   = 200;

    logic                  clk;
    logic                  rst_n;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic [NUM_COLS-1:0]   col_out;
    logic [NUM_ROWS-1:0]   row_in;
    logic                  irq;
    logic [15:0]           pressed;
    logic [15:0]           lfsr;
    int                    errors;
    int                    timeouts;
    int                    key_order[16];

    initial clk = 1'b0;
    always #5 clk = ~clk;

    keypad_top #(.COL_DWELL(COL_DWELL_TB), .DEBOUNCE_FRAMES(DEBOUNCE_TB)) dut (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .col_out, .row_in, .irq
    );

    keypad_matrix_model u_matrix (.col_out, .pressed, .row_in);

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("ERROR @%0t: %s, got %h, expected %h", $time, what, got, exp);
    endtask

    // taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | lfsr[0];
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic shuffle_keys();
        int r;
        int j;
        int tmp;
        for (int i = 0; i < 16; i++) key_order[i] = i;
        for (int i = 15; i > 0; i--) begin
            random_bits(4, r);
            j            = r % (i + 1);
            tmp          = key_order[i];
            key_order[i] = key_order[j];
            key_order[j] = tmp;
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int n;
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        n = 0;
        @(negedge clk);  // prdata and pready are settled mid-cycle.
        while (!pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            timeouts++;
            $display("APB access to address %h was never completed by the slave", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_transfer(1'b1, addr, data, unused, err);
        if (err !== 1'b0) mismatch("pslverr on write", {31'd0, err}, 32'd0);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic poll_status(input logic [31:0] mask, input logic [31:0] want,
                               input string what);
        logic [31:0] rd;
        logic        err;
        int          n;
        n = 0;
        apb_read(ADDR_STATUS, rd, err);
        while (((rd & mask) !== want) && n < POLL_LIMIT) begin
            apb_read(ADDR_STATUS, rd, err);
            n++;
        end
        if ((rd & mask) !== want) begin
            timeouts++;
            $display("gave up waiting for %s at %0t, STATUS stayed %h", what, $time, rd);
        end
    endtask

    task automatic idle_frames(input int n);
        repeat (n * FRAME_CYCLES) @(posedge clk);
    endtask

    task automatic press_key(input int k);
        @(posedge clk);
        #1;
        pressed[k] = 1'b1;
    endtask

    task automatic release_keys();
        @(posedge clk);
        #1;
        pressed = '0;
    endtask

    function automatic logic [31:0] data_word(input int k);
        return 32'h100 | ((k / NUM_COLS) * 4 + (k % NUM_COLS));  // valid bit plus row*4+col.
    endfunction

    task automatic reset_state();
        logic [31:0] rd;
        logic        err;
        if (col_out !== 4'hF) mismatch("col_out after reset", {28'd0, col_out}, 32'hF);
        if (irq !== 1'b0) mismatch("irq after reset", {31'd0, irq}, 32'd0);
        apb_read(ADDR_CTRL, rd, err);
        if (rd !== 32'd0) mismatch("CTRL after reset", rd, 32'd0);
        if (err !== 1'b0) mismatch("pslverr on CTRL", {31'd0, err}, 32'd0);
        apb_read(ADDR_STATUS, rd, err);
        if (rd !== 32'd0) mismatch("STATUS after reset", rd, 32'd0);
        apb_read(4'hC, rd, err);
        if (err !== 1'b1) mismatch("pslverr on unmapped address", {31'd0, err}, 32'd1);
    endtask

    task automatic decode_all_keys();
        logic [31:0] rd;
        logic        err;
        apb_write(ADDR_CTRL, 32'h1);
        shuffle_keys();
        for (int i = 0; i < 16; i++) begin
            press_key(key_order[i]);
            poll_status(32'h1, 32'h1, "a key entry");
            apb_read(ADDR_DATA, rd, err);
            if (rd !== data_word(key_order[i])) begin
                mismatch("DATA for key", rd, data_word(key_order[i]));
            end
            release_keys();
            poll_status(32'h1, 32'h0, "an empty FIFO");
            idle_frames(4);
        end
    endtask

    task automatic one_entry_per_press();
        logic [31:0] rd;
        logic        err;
        for (int pass = 0; pass < 2; pass++) begin
            press_key(9);
            poll_status(32'h1, 32'h1, "the held key");
            idle_frames(10);
            apb_read(ADDR_STATUS, rd, err);
            if (rd !== 32'h11) mismatch("STATUS with a held key", rd, 32'h11);
            apb_read(ADDR_DATA, rd, err);
            if (rd !== data_word(9)) mismatch("DATA for held key", rd, data_word(9));
            release_keys();
            idle_frames(5);  // a stable empty frame rearms the same key.
            apb_read(ADDR_STATUS, rd, err);
            if (rd !== 32'd0) mismatch("STATUS after release", rd, 32'd0);
        end
    endtask

    task automatic glitch_rejected();
        logic [31:0] rd;
        logic        err;
        press_key(5);
        repeat (20) @(posedge clk);
        release_keys();
        idle_frames(6);
        apb_read(ADDR_STATUS, rd, err);
        if (rd !== 32'd0) mismatch("STATUS after a short press", rd, 32'd0);
    endtask

    task automatic ghost_flagged();
        logic [31:0] rd;
        logic        err;
        press_key(0);
        press_key(6);  // row 1, column 2.
        poll_status(32'h4, 32'h4, "the ghost flag");
        apb_read(ADDR_STATUS, rd, err);
        if (rd !== 32'h4) mismatch("STATUS after ghost", rd, 32'h4);
        release_keys();
        idle_frames(5);
        apb_write(ADDR_STATUS, 32'h4);
        apb_read(ADDR_STATUS, rd, err);
        if (rd !== 32'd0) mismatch("STATUS after ghost clear", rd, 32'd0);
    endtask

    task automatic overflow_and_irq();
        logic [31:0] rd;
        logic        err;
        apb_write(ADDR_CTRL, 32'h3);
        if (irq !== 1'b0) mismatch("irq with empty FIFO", {31'd0, irq}, 32'd0);
        for (int i = 0; i < 9; i++) begin
            press_key(key_order[i]);
            if (i < 8) poll_status(32'hF0, (i + 1) << 4, "the FIFO count");
            else poll_status(32'h2, 32'h2, "the overflow flag");
            if (i == 0 && irq !== 1'b1) mismatch("irq with one entry", {31'd0, irq}, 32'd1);
            release_keys();
            idle_frames(4);
        end
        apb_read(ADDR_STATUS, rd, err);
        if (rd !== 32'h83) mismatch("STATUS when full", rd, 32'h83);
        for (int i = 0; i < 8; i++) begin
            apb_read(ADDR_DATA, rd, err);
            if (rd !== data_word(key_order[i])) begin
                mismatch("DATA order", rd, data_word(key_order[i]));
            end
        end
        if (irq !== 1'b0) mismatch("irq after draining", {31'd0, irq}, 32'd0);
        apb_read(ADDR_DATA, rd, err);
        if (rd !== 32'd0) mismatch("DATA from empty FIFO", rd, 32'd0);
        apb_write(ADDR_STATUS, 32'h2);
        apb_read(ADDR_STATUS, rd, err);
        if (rd !== 32'd0) mismatch("STATUS after overflow clear", rd, 32'd0);
    endtask

    initial begin
        errors   = 0;
        timeouts = 0;
        lfsr     = 16'd47337;
        rst_n    = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        pressed  = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state();
        decode_all_keys();
        one_entry_per_press();
        glitch_rejected();
        ghost_flagged();
        overflow_and_irq();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
